// ==== include/memAlign_consts.svh ====
`ifndef MEMALIGN_CONSTS_SVH
`define MEMALIGN_CONSTS_SVH

// data cache line geometry
`define LINE_BYTES 16
`define OFFSET_BITS 4

// 4 KB pages, 32-bit virtual address
`define PAGE_BITS 12
`define VPN_BITS 20

// physical memory is 8 frames deep
`define PFN_BITS 3

// translation buffer size
`define TLB_ENTRIES 8
`define TLB_INDEX_BITS 3

// per access payload
`define REQ_DATA_BYTES 8
`define TAG_BITS 4

`endif

// ==== hw/memAlignPkg.sv ====
`include "memAlign_consts.svh"

package memAlignPkg;

    // byte count is 1 << size
    typedef enum logic [1:0] {
        sizeByte   = 2'd0,
        sizeHalf   = 2'd1,
        sizeWord   = 2'd2,
        sizeDouble = 2'd3
    } accessSize_t;

    typedef enum logic [1:0] {
        none       = 2'd0,
        tlbMiss    = 2'd1,
        protection = 2'd2
    } faultKind_t;

    typedef struct packed {
        logic [31:0]                   addr;
        accessSize_t                   size;
        logic                          write;
        logic [8*`REQ_DATA_BYTES-1:0]  data;
        logic [`TAG_BITS-1:0]          tag;
    } memReq_t;

    typedef struct packed {
        logic                  valid;
        logic [`VPN_BITS-1:0]  vpn;
        logic [`PFN_BITS-1:0]  frame;
        logic                  writable;
    } tlbEntry_t;

    typedef struct packed {
        logic                        valid;
        logic                        flush;
        logic [`TLB_INDEX_BITS-1:0]  index;
        tlbEntry_t                   entry;
    } tlbWrite_t;

    // lineAddr is frame followed by virtual address bits 11..4
    typedef struct packed {
        logic [`PFN_BITS+`PAGE_BITS-`OFFSET_BITS-1:0]  lineAddr;
        logic [`LINE_BYTES-1:0]                        mask;
        logic [8*`LINE_BYTES-1:0]                      data;
        logic                                          write;
        logic [`TAG_BITS-1:0]                          tag;
        logic                                          last;
        faultKind_t                                    fault;
    } lineReq_t;

    typedef struct packed {
        lineReq_t  line0;
        lineReq_t  line1;
        logic      needSecond;
    } splitResult_t;

endpackage

// ==== hw/tlbConfig.sv ====
`timescale 1ns/1ps
`include "memAlign_consts.svh"

module tlbConfig (
    input  logic                                      clk,
    input  logic                                      reset,
    input  memAlignPkg::tlbWrite_t                    tlbWrite,
    output memAlignPkg::tlbEntry_t [`TLB_ENTRIES-1:0] entries
);

    memAlignPkg::tlbEntry_t [`TLB_ENTRIES-1:0] entryReg;

    // only the valid bits are cleared, the rest is payload
    always_ff @(posedge clk) begin
        if (reset || tlbWrite.flush) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entryReg[i].valid <= 1'b0;
            end
        end else if (tlbWrite.valid) begin
            entryReg[tlbWrite.index] <= tlbWrite.entry;
        end
    end

    // shared by both lookups in the splitter
    assign entries = entryReg;

endmodule

// ==== hw/tlbLookup.sv ====
`timescale 1ns/1ps
`include "memAlign_consts.svh"

module tlbLookup (
    input  memAlignPkg::tlbEntry_t [`TLB_ENTRIES-1:0] entries,
    input  logic [`VPN_BITS-1:0]                      vpn,
    output logic                                      hit,
    output logic [`PFN_BITS-1:0]                      frame,
    output logic                                      writable
);

    logic [`TLB_ENTRIES-1:0] match;

    // one comparator per entry
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = entries[i].valid && (entries[i].vpn == vpn);
        end
    end

    // walk down from the top so the lowest matching index is left
    always_comb begin
        hit      = 1'b0;
        frame    = '0;
        writable = 1'b0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit      = 1'b1;
                frame    = entries[i].frame;
                writable = entries[i].writable;
            end
        end
    end

endmodule

// ==== hw/accessSplitter.sv ====
`timescale 1ns/1ps
`include "memAlign_consts.svh"

module accessSplitter (
    input  memAlignPkg::memReq_t                      req,
    input  memAlignPkg::tlbEntry_t [`TLB_ENTRIES-1:0] entries,
    output memAlignPkg::splitResult_t                 result
);

    logic [31:0]                    nextLineAddr;
    logic [`OFFSET_BITS-1:0]        offset;
    logic [3:0]                     byteCount;
    logic [`OFFSET_BITS:0]          endOffset;
    logic                           needSecond;
    logic [`REQ_DATA_BYTES-1:0]     sizeMask;
    logic [2*`LINE_BYTES-1:0]       wideMask;
    logic [8*`REQ_DATA_BYTES-1:0]   laneData;
    logic [16*`LINE_BYTES-1:0]      wideData;
    logic                           hit0;
    logic                           hit1;
    logic                           writable0;
    logic                           writable1;
    logic [`PFN_BITS-1:0]           frame0;
    logic [`PFN_BITS-1:0]           frame1;
    logic                           missFault;
    logic                           protFault;

    assign nextLineAddr = req.addr + 32'(`LINE_BYTES);
    assign offset       = req.addr[`OFFSET_BITS-1:0];
    assign byteCount    = 4'd1 << req.size;

    // last byte touched, bit 4 set means it spills into the next line
    assign endOffset  = {1'b0, offset} + {1'b0, byteCount} - 5'd1;
    assign needSecond = endOffset[`OFFSET_BITS];

    assign sizeMask = 8'((9'd1 << byteCount) - 9'd1);

    // drop bytes beyond the access size, reads carry no data
    for (genvar b = 0; b < `REQ_DATA_BYTES; b++) begin : gLane
        assign laneData[8*b +: 8] = (req.write && sizeMask[b]) ? req.data[8*b +: 8] : 8'h00;
    end

    // shift across two lines at once, upper half belongs to line1
    assign wideMask = {{(2*`LINE_BYTES - `REQ_DATA_BYTES){1'b0}}, sizeMask} << offset;
    assign wideData = {{(16*`LINE_BYTES - 8*`REQ_DATA_BYTES){1'b0}}, laneData}
                      << {offset, 3'b000};

    tlbLookup lookup0 (
        .entries  (entries),
        .vpn      (req.addr[31:`PAGE_BITS]),
        .hit      (hit0),
        .frame    (frame0),
        .writable (writable0)
    );

    tlbLookup lookup1 (
        .entries  (entries),
        .vpn      (nextLineAddr[31:`PAGE_BITS]),
        .hit      (hit1),
        .frame    (frame1),
        .writable (writable1)
    );

    // the second translation only counts when the access spills over
    assign missFault = !hit0 || (needSecond && !hit1);
    assign protFault = req.write && (!writable0 || (needSecond && !writable1));

    always_comb begin
        result.line0.lineAddr = {frame0, req.addr[`PAGE_BITS-1:`OFFSET_BITS]};
        result.line0.mask     = wideMask[`LINE_BYTES-1:0];
        result.line0.data     = wideData[8*`LINE_BYTES-1:0];
        result.line0.write    = req.write;
        result.line0.tag      = req.tag;
        result.line0.last     = !needSecond;
        result.line0.fault    = memAlignPkg::none;

        result.line1.lineAddr = {frame1, nextLineAddr[`PAGE_BITS-1:`OFFSET_BITS]};
        result.line1.mask     = wideMask[2*`LINE_BYTES-1:`LINE_BYTES];
        result.line1.data     = wideData[16*`LINE_BYTES-1:8*`LINE_BYTES];
        result.line1.write    = req.write;
        result.line1.tag      = req.tag;
        result.line1.last     = 1'b1;
        result.line1.fault    = memAlignPkg::none;

        result.needSecond = needSecond;

        // a fault collapses the access into a single empty item
        if (missFault || protFault) begin
            result.line0.lineAddr = '0;
            result.line0.mask     = '0;
            result.line0.data     = '0;
            result.line0.last     = 1'b1;
            result.line0.fault    = missFault ? memAlignPkg::tlbMiss : memAlignPkg::protection;
            result.needSecond     = 1'b0;
        end
    end

endmodule

// ==== hw/lineIssue.sv ====
`timescale 1ns/1ps

module lineIssue (
    input  logic                      clk,
    input  logic                      reset,
    input  memAlignPkg::splitResult_t result,
    input  logic                      reqValid,
    output logic                      reqReady,
    output memAlignPkg::lineReq_t     line,
    output logic                      lineValid,
    input  logic                      lineReady
);

    memAlignPkg::lineReq_t curItem;
    memAlignPkg::lineReq_t pendItem;
    logic                  full;
    logic                  hasPending;
    logic                  accept;
    logic                  transfer;

    // free, or the last item of the access is leaving now
    assign reqReady = !full || (curItem.last && lineReady);

    assign accept   = reqValid && reqReady;
    assign transfer = full && lineReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            full       <= 1'b0;
            hasPending <= 1'b0;
        end else if (accept) begin
            full       <= 1'b1;
            hasPending <= result.needSecond;
        end else if (transfer) begin
            if (hasPending) begin
                hasPending <= 1'b0;
            end else begin
                full <= 1'b0;
            end
        end
    end

    // line0 goes out first, line1 waits behind it
    always_ff @(posedge clk) begin
        if (accept) begin
            curItem  <= result.line0;
            pendItem <= result.line1;
        end else if (transfer && hasPending) begin
            curItem <= pendItem;
        end
    end

    assign line      = curItem;
    assign lineValid = full;

endmodule

// ==== hw/memAlign.sv ====
`timescale 1ns/1ps
`include "memAlign_consts.svh"

module memAlign (
    input  logic                   clk,
    input  logic                   reset,
    input  memAlignPkg::memReq_t   req,
    input  logic                   reqValid,
    output logic                   reqReady,
    output memAlignPkg::lineReq_t  line,
    output logic                   lineValid,
    input  logic                   lineReady,
    input  memAlignPkg::tlbWrite_t tlbWrite
);

    memAlignPkg::tlbEntry_t [`TLB_ENTRIES-1:0] entries;
    memAlignPkg::splitResult_t                 splitResult;

    tlbConfig tlbRegs (
        .clk      (clk),
        .reset    (reset),
        .tlbWrite (tlbWrite),
        .entries  (entries)
    );

    // combinational split and translate
    accessSplitter splitter (
        .req     (req),
        .entries (entries),
        .result  (splitResult)
    );

    lineIssue issue (
        .clk       (clk),
        .reset     (reset),
        .result    (splitResult),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .line      (line),
        .lineValid (lineValid),
        .lineReady (lineReady)
    );

endmodule

// ==== sim/memAlignTb.sv ====
`timescale 1ns/1ps
`include "memAlign_consts.svh"

module memAlignTb;

    localparam int ACCESS_PER_TEST = 40;
    localparam int TEST_COUNT      = 6;
    localparam int RESET_CYCLES    = 5;
    localparam int CYCLE_LIMIT     = 2 * ACCESS_PER_TEST * TEST_COUNT * 4 + RESET_CYCLES;

    logic                   clk;
    logic                   reset;
    memAlignPkg::memReq_t   req;
    logic                   reqValid;
    logic                   reqReady;
    memAlignPkg::lineReq_t  line;
    logic                   lineValid;
    logic                   lineReady;
    memAlignPkg::tlbWrite_t tlbWrite;

    memAlignPkg::tlbEntry_t mirror [`TLB_ENTRIES];
    memAlignPkg::lineReq_t  expQ [$];
    memAlignPkg::lineReq_t  heldLine;
    logic                   stalled;
    logic [31:0]            lfsr;
    int                     errorCount;
    int                     itemCount;
    int                     testCount;
    int                     cycleCount;

    memAlign DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // right shifting galois lfsr
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsrNext(lfsr);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [191:0] expected,
                              input logic [191:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // expected items of one accepted access built byte by byte
    task automatic predict(input memAlignPkg::memReq_t r);
        memAlignPkg::lineReq_t item [2];
        logic [31:0]           lineBase [2];
        logic                  hit [2];
        logic [2:0]            frame [2];
        logic                  writable [2];
        logic                  need2;
        logic                  miss;
        int                    n;
        int                    pos;
        n = 1 << r.size;
        need2 = int'(r.addr[3:0]) + n > 16;
        lineBase[0] = r.addr;
        lineBase[1] = r.addr + 32'd16;
        for (int s = 0; s < 2; s++) begin
            hit[s] = 1'b0;
            frame[s] = '0;
            writable[s] = 1'b0;
            // first valid match from index 0 up
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (!hit[s] && mirror[i].valid && mirror[i].vpn == lineBase[s][31:12]) begin
                    hit[s] = 1'b1;
                    frame[s] = mirror[i].frame;
                    writable[s] = mirror[i].writable;
                end
            end
            item[s] = '0;
            item[s].lineAddr = {frame[s], lineBase[s][11:4]};
            item[s].write = r.write;
            item[s].tag = r.tag;
        end
        miss = !hit[0] || (need2 && !hit[1]);
        if (miss || (r.write && (!writable[0] || (need2 && !writable[1])))) begin
            item[0].lineAddr = '0;
            item[0].last = 1'b1;
            item[0].fault = miss ? memAlignPkg::tlbMiss : memAlignPkg::protection;
            expQ.push_back(item[0]);
        end else begin
            for (int j = 0; j < n; j++) begin
                pos = int'(r.addr[3:0]) + j;
                item[pos / 16].mask[pos % 16] = 1'b1;
                if (r.write) begin
                    item[pos / 16].data[8 * (pos % 16) +: 8] = r.data[8 * j +: 8];
                end
            end
            item[0].last = !need2;
            item[1].last = 1'b1;
            expQ.push_back(item[0]);
            if (need2) begin
                expQ.push_back(item[1]);
            end
        end
    endtask

    // drive on the falling edge and then judge what the next rising edge does
    task automatic stepCycle(input memAlignPkg::memReq_t r, input logic rv, input logic lr,
                             input memAlignPkg::tlbWrite_t w, output logic accepted);
        memAlignPkg::lineReq_t expItem;
        @(negedge clk);
        req = r;
        reqValid = rv;
        lineReady = lr;
        tlbWrite = w;
        #1;
        // queued items are the ones the issue stage still holds
        checkValue("lineValid", 192'(expQ.size() != 0), 192'(lineValid));
        checkValue("reqReady", 192'(expQ.size() == 0 || (expQ.size() == 1 && lr)),
                   192'(reqReady));
        if (stalled) begin
            checkValue("line", 192'(heldLine), 192'(line));
        end
        if (lineValid && lr) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("line item at %0t arrived with no access outstanding", $time);
            end else begin
                expItem = expQ.pop_front();
                checkValue("line.lineAddr", 192'(expItem.lineAddr), 192'(line.lineAddr));
                checkValue("line.mask", 192'(expItem.mask), 192'(line.mask));
                checkValue("line.data", 192'(expItem.data), 192'(line.data));
                checkValue("line.write", 192'(expItem.write), 192'(line.write));
                checkValue("line.tag", 192'(expItem.tag), 192'(line.tag));
                checkValue("line.last", 192'(expItem.last), 192'(line.last));
                checkValue("line.fault", 192'(expItem.fault), 192'(line.fault));
                itemCount++;
            end
        end
        accepted = rv && reqReady;
        if (accepted) begin
            predict(r);
        end
        stalled = lineValid && !lr;
        heldLine = line;
        // a TLB write is seen only by later accesses
        if (w.flush) begin
            foreach (mirror[i]) begin
                mirror[i].valid = 1'b0;
            end
        end else if (w.valid) begin
            mirror[w.index] = w.entry;
        end
    endtask

    function automatic memAlignPkg::memReq_t genAccess(input int mode);
        memAlignPkg::memReq_t r;
        int                   n;
        logic [3:0]           off;
        logic [7:0]           lineIdx;
        logic [19:0]          page;
        r.size = memAlignPkg::accessSize_t'(2'(randBits(2)));
        if ((mode == 1 || mode == 2) && r.size == memAlignPkg::sizeByte) begin
            r.size = memAlignPkg::sizeHalf;
        end
        n = 1 << r.size;
        // pages 0x100 to 0x107 are loaded and the fault test also reaches unmapped ones
        page = 20'h00100 + 20'(randBits(mode == 3 ? 4 : 3));
        off = 4'(randBits(4));
        lineIdx = 8'(randBits(8));
        if (mode == 0) begin
            off = off & ~4'(n - 1);
        end
        if (mode == 1 || mode == 2) begin
            page = 20'h00100 + 20'(randBits(3) % 7);
            off = 4'(17 - n + int'(randBits(3)) % (n - 1));
        end
        if (mode == 2 || (mode == 3 && randBits(1) != 0)) begin
            lineIdx = 8'hff;
        end
        r.addr = {page, lineIdx, off};
        r.write = randBits(1) != 0;
        r.data = {randBits(32), randBits(32)};
        r.tag = 4'(randBits(4));
        return r;
    endfunction

    task automatic loadTlb(input int mode);
        memAlignPkg::tlbWrite_t w;
        logic                   acc;
        w = '0;
        w.flush = 1'b1;
        stepCycle(req, 1'b0, 1'b1, w, acc);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            w = '0;
            w.valid = 1'b1;
            w.index = i[`TLB_INDEX_BITS-1:0];
            w.entry.valid = 1'b1;
            w.entry.vpn = 20'h00100 + 20'(i);
            // neighbouring pages get distinct frames for the page crossing test
            w.entry.frame = (mode == 2) ? 3'(7 - i) : 3'(randBits(3));
            w.entry.writable = (mode != 3) || (i % 2 == 0);
            stepCycle(req, 1'b0, 1'b1, w, acc);
        end
    endtask

    task automatic runTest(input string name, input int mode);
        memAlignPkg::memReq_t   r;
        memAlignPkg::tlbWrite_t w;
        logic                   acc;
        logic                   rv;
        logic                   lr;
        int                     issued;
        int                     startErrors;
        int                     startItems;
        startErrors = errorCount;
        startItems = itemCount;
        issued = 0;
        loadTlb(mode);
        r = genAccess(mode);
        while (issued < ACCESS_PER_TEST) begin
            rv = randBits(2) != 0;
            lr = (mode == 4) ? (randBits(1) != 0) : (randBits(2) != 0);
            w = '0;
            if (mode == 5 && randBits(3) == 0) begin
                w.flush = randBits(2) == 0;
                w.valid = 1'b1;
                w.index = 3'(randBits(3));
                w.entry.valid = 1'b1;
                w.entry.vpn = 20'h00100 + 20'(randBits(3));
                w.entry.frame = 3'(randBits(3));
                w.entry.writable = randBits(1) != 0;
            end
            stepCycle(r, rv, lr, w, acc);
            if (acc) begin
                issued++;
                r = genAccess(mode);
            end
        end
        // drain what is still in flight
        while (expQ.size() > 0) begin
            w = '0;
            stepCycle(r, 1'b0, randBits(1) != 0, w, acc);
        end
        testCount++;
        $display("test %s: %0d accesses, %0d items, %0d errors", name, ACCESS_PER_TEST,
                 itemCount - startItems, errorCount - startErrors);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        req = '0;
        reqValid = 1'b0;
        lineReady = 1'b0;
        tlbWrite = '0;
        lfsr = 32'h3abf25b7;
        errorCount = 0;
        itemCount = 0;
        testCount = 0;
        stalled = 1'b0;
        foreach (mirror[i]) begin
            mirror[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        #1;
        checkValue("lineValid", 192'(1'b0), 192'(lineValid));
        checkValue("reqReady", 192'(1'b1), 192'(reqReady));
        testCount++;
        $display("test reset: %0d errors", errorCount);
        runTest("aligned", 0);
        runTest("crossLine", 1);
        runTest("crossPage", 2);
        runTest("faults", 3);
        runTest("backPressure", 4);
        runTest("tlbRewrite", 5);
        $display("%0d tests, %0d items checked, %0d errors", testCount, itemCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== memAlign.f ====
+incdir+include
hw/memAlignPkg.sv
hw/tlbConfig.sv
hw/tlbLookup.sv
hw/accessSplitter.sv
hw/lineIssue.sv
hw/memAlign.sv
sim/memAlignTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= memAlignTb
FILELIST  ?= memAlign.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
FAIL_MSG  ?= Verification failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
